/* project.f */
+incdir+src
src/tmr_pkg.sv
src/tmr_event_sync.sv
src/tmr_mode_fsm.sv
src/tmr_count.sv
src/tmr_wave_out.sv
src/tmr_capture_bank.sv
src/tmr_top.sv
dv/tmr_checker.sv
dv/tmr_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tmr_tb -Mdir obj_dir -o tmr_sim \
    && ./obj_dir/tmr_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

/* dv/tmr_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_tb;
    import tmr_pkg::*;

    localparam int SEG_N       = 12;
    localparam int SEG_LEN     = 400;
    localparam int WATCHDOG_NS = SEG_N * (SEG_LEN + 2) * 100 + 10000;

    logic                    clk;
    logic                    rst_n;
    tmr_cfg_t                cfg;
    logic                    ext_a;
    logic                    ext_b;
    logic                    trig_start;
    logic                    trig_stop;
    logic [`TMR_INNER_N-1:0] inner;
    logic [`TMR_BANK_N-1:0]  rd_ack_a;
    logic [`TMR_BANK_N-1:0]  rd_ack_b;
    tmr_pins_t               pins;
    tmr_bank_t               cap_a;
    tmr_bank_t               cap_b;
    logic [2:0]              irq;
    logic [31:0]             lfsr;

    // reference model state.
    logic [1:0]            m_sync [4];   // start, stop, cap_a, cap_b.
    logic                  m_prev [4];
    tmr_state_e            m_state;
    logic [`TMR_CNT_W-1:0] m_cnt;
    tmr_pins_t             m_pins;
    logic                  m_per_d;
    logic                  m_per_int;
    tmr_bank_t             m_bank [2];
    logic [1:0]            m_ptr [2];
    logic [2:0]            m_ack_d [2];
    logic                  m_full_d [2];
    logic                  m_full_int [2];

    tmr_top DUT (
        .i_clk(clk), .i_rst_n(rst_n), .i_cfg(cfg),
        .i_ext_a(ext_a), .i_ext_b(ext_b),
        .i_trig_start(trig_start), .i_trig_stop(trig_stop),
        .i_inner(inner), .i_rd_ack_a(rd_ack_a), .i_rd_ack_b(rd_ack_b),
        .o_pins(pins), .o_cap_a(cap_a), .o_cap_b(cap_b), .o_int(irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired before all test segments finished");
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_pins(input tmr_pins_t exp, input tmr_pins_t got);
        if (exp !== got) begin
            fail_stop($sformatf("Mismatch at %0t: o_pins expected %h, got %h", $time, exp, got));
        end
    endtask

    task automatic check_bank(input string name, input tmr_bank_t exp, input tmr_bank_t got);
        if (exp !== got) begin
            fail_stop($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_int(input logic [2:0] exp, input logic [2:0] got);
        if (exp !== got) begin
            fail_stop($sformatf("Mismatch at %0t: o_int expected %b, got %b", $time, exp, got));
        end
    endtask

    task automatic check_all();
        check_pins(m_pins, pins);
        check_bank("o_cap_a", m_bank[0], cap_a);
        check_bank("o_cap_b", m_bank[1], cap_b);
        check_int({m_per_int, m_full_int[1], m_full_int[0]}, irq);
    endtask

    function automatic logic pick_source(input tmr_src_e src);
        case (src)
            src_ext_a:      return ext_a;
            src_ext_b:      return ext_b;
            src_trig_start: return trig_start;
            src_trig_stop:  return trig_stop;
            src_inner0:     return inner[0];
            src_inner1:     return inner[1];
            src_inner2:     return inner[2];
            default:        return inner[3];
        endcase
    endfunction

    function automatic logic edge_seen(input tmr_edge_e rule, input logic cur, input logic old);
        case (rule)
            edge_rise: return cur && !old;
            edge_fall: return !cur && old;
            edge_both: return cur != old;
            default:   return 1'b0;
        endcase
    endfunction

    // level after the compare matches of one pin.
    function automatic logic wave_level(input logic lvl, input logic [2:0] m,
                                        input tmr_pin_cfg_t pc);
        if (m[0]) return 1'b0;
        if (m[1]) return 1'b1;
        if (m[2] && !pc.keep) return pc.idle_lvl;
        return lvl;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 4; i++) begin
            m_sync[i] = 2'b00;
            m_prev[i] = 1'b0;
        end
        m_state   = st_idle;
        m_cnt     = '0;
        m_pins    = '{dout_a: 1'b0, oen_a: 1'b1, dout_b: 1'b0, oen_b: 1'b1};
        m_per_d   = 1'b0;
        m_per_int = 1'b0;
        for (int b = 0; b < 2; b++) begin
            m_bank[b]     = '0;
            m_ptr[b]      = 2'd0;
            m_ack_d[b]    = 3'b000;
            m_full_d[b]   = 1'b0;
            m_full_int[b] = 1'b0;
        end
    endtask

    // one rising edge of the whole design.
    task automatic model_step();
        tmr_chan_cfg_t ch [4];
        logic          ev [4];
        logic [2:0]    ma;
        logic [2:0]    mb;
        logic          wave;
        logic          halt_m;
        logic          restart;
        logic          per_hit;
        logic [2:0]    ovw [2];
        logic [2:0]    ack [2];
        logic          strobe [2];
        logic [2:0]    rise;
        logic          cap;
        ch[0] = cfg.ch_start;
        ch[1] = cfg.ch_stop;
        ch[2] = cfg.ch_cap_a;
        ch[3] = cfg.ch_cap_b;
        for (int i = 0; i < 4; i++) begin
            ev[i]     = edge_seen(ch[i].edge_sel, m_sync[i][1], m_prev[i]);
            m_prev[i] = m_sync[i][1];
            m_sync[i] = {m_sync[i][0], pick_source(ch[i].src)};
        end
        for (int k = 0; k < 3; k++) begin
            ma[k] = (m_cnt == cfg.cmp_a[k]);
            mb[k] = (m_cnt == cfg.cmp_b[k]);
        end
        wave    = (m_state == st_wave);
        halt_m  = wave && ((ma[2] && cfg.pin_a.halt) || (mb[2] && cfg.pin_b.halt));
        restart = wave && ((ma[2] && !cfg.pin_a.halt) || (mb[2] && !cfg.pin_b.halt));
        per_hit = wave && (ma[2] || mb[2]);

        strobe[0] = ev[2];
        strobe[1] = ev[3];
        ovw[0]    = cfg.ovw_a;
        ovw[1]    = cfg.ovw_b;
        ack[0]    = rd_ack_a;
        ack[1]    = rd_ack_b;
        for (int b = 0; b < 2; b++) begin
            m_full_int[b] = (&m_bank[b].status) && !m_full_d[b];
            m_full_d[b]   = &m_bank[b].status;
            rise          = ack[b] & ~m_ack_d[b];
            m_ack_d[b]    = ack[b];
            if (!cfg.enable) begin
                m_bank[b] = '0;
                m_ptr[b]  = 2'd0;
            end else begin
                cap = strobe[b] && (m_state == st_capt);
                if (cap && (!m_bank[b].status[m_ptr[b]] || ovw[b][m_ptr[b]])) begin
                    m_bank[b].values[m_ptr[b]] = m_cnt;
                end
                m_bank[b].status = (m_bank[b].status & ~rise) |
                                   (cap ? (3'b001 << m_ptr[b]) : 3'b000);
                if (cap) begin
                    m_ptr[b] = (m_ptr[b] == 2'd2) ? 2'd0 : m_ptr[b] + 2'd1;
                end
            end
        end

        if (!cfg.enable || ev[1]) begin
            m_pins.oen_a = 1'b1;
            m_pins.oen_b = 1'b1;
        end else if (ev[0]) begin
            if (cfg.mode == mode_wave) begin
                m_pins = '{dout_a: cfg.pin_a.idle_lvl, oen_a: 1'b0,
                           dout_b: cfg.pin_b.idle_lvl, oen_b: 1'b0};
            end else begin
                m_pins.oen_a = 1'b1;
                m_pins.oen_b = 1'b1;
            end
        end else if (wave) begin
            m_pins.dout_a = wave_level(m_pins.dout_a, ma, cfg.pin_a);
            m_pins.dout_b = wave_level(m_pins.dout_b, mb, cfg.pin_b);
            if (halt_m) begin
                m_pins.oen_a = 1'b1;
                m_pins.oen_b = 1'b1;
            end
        end
        m_per_int = per_hit && !m_per_d;
        m_per_d   = per_hit;

        if (!cfg.enable) begin
            m_cnt = '0;
        end else if (m_state != st_idle) begin
            m_cnt = restart ? '0 : m_cnt + 1;
        end
        if (!cfg.enable || ev[1]) begin
            m_state = st_idle;
        end else if (ev[0]) begin
            m_state = (cfg.mode == mode_wave) ? st_wave : st_capt;
        end else if (halt_m) begin
            m_state = st_idle;
        end
    endtask

    // new segment config, enable stays low until the segment runs.
    task automatic new_config();
        logic [1:0] e;
        cfg              = '0;
        cfg.mode         = (draw_bits(1) != 0) ? mode_wave : mode_capt;
        cfg.ch_start.src = src_trig_start;
        e                = 2'(draw_bits(2));
        cfg.ch_start.edge_sel = tmr_edge_e'((e == 2'd3) ? 2'd2 : e);   // never none.
        cfg.ch_stop.src       = src_trig_stop;
        cfg.ch_stop.edge_sel  = tmr_edge_e'(2'(draw_bits(2)));
        cfg.ch_cap_a.src      = tmr_src_e'(3'(draw_bits(3)));
        cfg.ch_cap_a.edge_sel = tmr_edge_e'(2'(draw_bits(2)));
        cfg.ch_cap_b.src      = tmr_src_e'(3'(draw_bits(3)));
        cfg.ch_cap_b.edge_sel = tmr_edge_e'(2'(draw_bits(2)));
        cfg.pin_a = '{keep: draw_bits(1) != 0, halt: draw_bits(1) != 0,
                      idle_lvl: draw_bits(1) != 0, spare: 1'b0};
        cfg.pin_b = '{keep: draw_bits(1) != 0, halt: draw_bits(1) != 0,
                      idle_lvl: draw_bits(1) != 0, spare: 1'b0};
        for (int k = 0; k < 3; k++) begin
            cfg.cmp_a[k] = draw_bits(6);   // small, reached within a run.
            cfg.cmp_b[k] = draw_bits(6);
        end
        cfg.ovw_a = 3'(draw_bits(3));
        cfg.ovw_b = 3'(draw_bits(3));
    endtask

    task automatic drive_inputs();
        if (draw_bits(2) == 0) ext_a = ~ext_a;
        if (draw_bits(2) == 0) ext_b = ~ext_b;
        if (draw_bits(5) == 0) trig_start = ~trig_start;
        if (draw_bits(6) == 0) trig_stop = ~trig_stop;   // rare, lets runs reach A2/B2.
        for (int k = 0; k < `TMR_INNER_N; k++) begin
            if (draw_bits(2) == 0) inner[k] = ~inner[k];
        end
        rd_ack_a = 3'(draw_bits(3) & draw_bits(3) & draw_bits(3));
        rd_ack_b = 3'(draw_bits(3) & draw_bits(3) & draw_bits(3));
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            drive_inputs();
            @(posedge clk);
            model_step();
            @(negedge clk);
            check_all();
        end
    endtask

    initial begin
        lfsr       = 32'h1f3d;
        rst_n      = 1'b0;
        cfg        = '0;
        ext_a      = 1'b0;
        ext_b      = 1'b0;
        trig_start = 1'b0;
        trig_stop  = 1'b0;
        inner      = '0;
        rd_ack_a   = '0;
        rd_ack_b   = '0;
        model_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_all();                       // idle outputs after reset.
        rst_n = 1'b1;
        for (int s = 0; s < SEG_N; s++) begin
            new_config();
            run_cycles(2);
            cfg.enable = 1'b1;
            run_cycles(SEG_LEN);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tmr_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_checker (
    input wire logic                   i_clk,
    input wire logic                   i_rst_n,
    input wire tmr_pkg::tmr_state_e    i_state,
    input wire tmr_pkg::tmr_pins_t     i_pins,
    input wire logic [2:0]             i_int,
    input wire logic                   i_strobe_a,
    input wire logic                   i_strobe_b,
    input wire logic [`TMR_BANK_N-1:0] i_status_a,
    input wire logic [`TMR_BANK_N-1:0] i_status_b
);
    import tmr_pkg::*;

    // interrupts are one-cycle pulses.
    int_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_int & $past(i_int)) == 3'b000)
        else $error("o_int bit high for two cycles in a row");

    idle_oen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == st_idle) |-> (i_pins.oen_a && i_pins.oen_b))
        else $error("output enable active while the timer is idle");

    // a status bit is only set by a capture strobe.
    stat_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (|(i_status_a & ~$past(i_status_a))) |-> $past(i_strobe_a))
        else $error("bank a status bit set without a strobe");

    stat_b: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (|(i_status_b & ~$past(i_status_b))) |-> $past(i_strobe_b))
        else $error("bank b status bit set without a strobe");

endmodule

bind tmr_top tmr_checker u_checker (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_state(state), .i_pins(o_pins), .i_int(o_int),
    .i_strobe_a(events.cap_a), .i_strobe_b(events.cap_b),
    .i_status_a(o_cap_a.status), .i_status_b(o_cap_b.status)
);

`default_nettype wire

/* src/tmr_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_top (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire tmr_pkg::tmr_cfg_t      i_cfg,
    input  wire logic                   i_ext_a,
    input  wire logic                   i_ext_b,
    input  wire logic                   i_trig_start,
    input  wire logic                   i_trig_stop,
    input  wire logic [`TMR_INNER_N-1:0] i_inner,
    input  wire logic [`TMR_BANK_N-1:0] i_rd_ack_a,
    input  wire logic [`TMR_BANK_N-1:0] i_rd_ack_b,
    output tmr_pkg::tmr_pins_t          o_pins,
    output tmr_pkg::tmr_bank_t          o_cap_a,
    output tmr_pkg::tmr_bank_t          o_cap_b,
    output logic [2:0]                  o_int
);
    import tmr_pkg::*;

    tmr_events_t           events;
    tmr_match_t            match;
    tmr_state_e            state;
    logic [`TMR_CNT_W-1:0] count;
    logic                  full_a;
    logic                  full_b;
    logic                  period_int;

    tmr_event_sync u_sync (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg(i_cfg),
        .i_ext_a(i_ext_a), .i_ext_b(i_ext_b),
        .i_trig_start(i_trig_start), .i_trig_stop(i_trig_stop),
        .i_inner(i_inner), .o_events(events)
    );

    tmr_mode_fsm u_fsm (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg(i_cfg),
        .i_events(events), .i_match(match), .o_state(state)
    );

    tmr_count u_count (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg(i_cfg),
        .i_state(state), .o_count(count), .o_match(match)
    );

    tmr_wave_out u_wave (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg(i_cfg), .i_events(events),
        .i_state(state), .i_match(match), .o_pins(o_pins), .o_period_int(period_int)
    );

    // bank a follows din0, bank b follows din1.
    tmr_capture_bank u_bank_a (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_enable(i_cfg.enable), .i_ovw(i_cfg.ovw_a),
        .i_strobe(events.cap_a), .i_state(state), .i_count(count),
        .i_rd_ack(i_rd_ack_a), .o_bank(o_cap_a), .o_full_int(full_a)
    );

    tmr_capture_bank u_bank_b (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_enable(i_cfg.enable), .i_ovw(i_cfg.ovw_b),
        .i_strobe(events.cap_b), .i_state(state), .i_count(count),
        .i_rd_ack(i_rd_ack_b), .o_bank(o_cap_b), .o_full_int(full_b)
    );

    assign o_int = {period_int, full_b, full_a};

endmodule

`default_nettype wire

/* src/tmr_capture_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_capture_bank (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_enable,
    input  wire logic [`TMR_BANK_N-1:0] i_ovw,
    input  wire logic                   i_strobe,
    input  wire tmr_pkg::tmr_state_e    i_state,
    input  wire logic [`TMR_CNT_W-1:0]  i_count,
    input  wire logic [`TMR_BANK_N-1:0] i_rd_ack,
    output tmr_pkg::tmr_bank_t          o_bank,
    output logic                        o_full_int
);
    import tmr_pkg::*;

    localparam int PTR_W = $clog2(`TMR_BANK_N);

    logic [PTR_W-1:0]                       ptr;
    logic [`TMR_BANK_N-1:0]                 status;
    logic [`TMR_BANK_N-1:0][`TMR_CNT_W-1:0] values;
    logic [`TMR_BANK_N-1:0]                 ack_d;
    logic [`TMR_BANK_N-1:0]                 ack_rise;
    logic [`TMR_BANK_N-1:0]                 set_mask;
    logic                                   cap_hit;
    logic                                   take;
    logic                                   all_set;
    logic                                   full_d;
    logic                                   full_int_q;

    assign cap_hit  = i_strobe && (i_state == st_capt);
    assign ack_rise = i_rd_ack & ~ack_d;
    assign set_mask = cap_hit ? (`TMR_BANK_N'(1) << ptr) : '0;

    // a full entry is written again only with its overwrite bit.
    assign take = cap_hit && (!status[ptr] || i_ovw[ptr]);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_d <= '0;
        end else begin
            ack_d <= i_rd_ack;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ptr    <= '0;
            status <= '0;
            values <= '0;
        end else if (!i_enable) begin
            ptr    <= '0;
            status <= '0;
            values <= '0;
        end else begin
            status <= (status & ~ack_rise) | set_mask;   // a new capture beats the ack.
            if (take) begin
                values[ptr] <= i_count;
            end
            if (cap_hit) begin
                if (ptr == PTR_W'(`TMR_BANK_N - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    // pulse on the cycle after the bank fills.
    assign all_set = &status;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full_d     <= 1'b0;
            full_int_q <= 1'b0;
        end else begin
            full_d     <= all_set;
            full_int_q <= all_set & ~full_d;
        end
    end

    assign o_bank     = '{values: values, status: status};
    assign o_full_int = full_int_q;

endmodule

`default_nettype wire

/* src/tmr_wave_out.sv */
`timescale 1ns/10ps
`default_nettype none

module tmr_wave_out (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire tmr_pkg::tmr_cfg_t    i_cfg,
    input  wire tmr_pkg::tmr_events_t i_events,
    input  wire tmr_pkg::tmr_state_e  i_state,
    input  wire tmr_pkg::tmr_match_t  i_match,
    output tmr_pkg::tmr_pins_t        o_pins,
    output logic                      o_period_int
);
    import tmr_pkg::*;

    tmr_pins_t pins_q;
    logic      in_wave;
    logic      halt_hit;
    logic      per_hit;
    logic      per_hit_d;
    logic      per_int_q;

    // x0 clears, x1 sets, x2 keeps or restores idle.
    function automatic logic pin_next(input logic cur, input logic [2:0] hit,
                                      input tmr_pin_cfg_t cfg);
        logic nxt;
        if (hit[0]) begin
            nxt = 1'b0;
        end else if (hit[1]) begin
            nxt = 1'b1;
        end else if (hit[2]) begin
            nxt = cfg.keep ? cur : cfg.idle_lvl;
        end else begin
            nxt = cur;
        end
        return nxt;
    endfunction

    assign in_wave  = (i_state == st_wave);
    assign halt_hit = in_wave && ((i_match.a[2] && i_cfg.pin_a.halt) ||
                                  (i_match.b[2] && i_cfg.pin_b.halt));
    assign per_hit  = in_wave && (i_match.a[2] || i_match.b[2]);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pins_q <= '{dout_a: 1'b0, oen_a: 1'b1, dout_b: 1'b0, oen_b: 1'b1};
        end else if (!i_cfg.enable || i_events.stop) begin
            pins_q.oen_a <= 1'b1;
            pins_q.oen_b <= 1'b1;
        end else if (i_events.start) begin
            if (i_cfg.mode == mode_wave) begin
                pins_q <= '{dout_a: i_cfg.pin_a.idle_lvl, oen_a: 1'b0,
                            dout_b: i_cfg.pin_b.idle_lvl, oen_b: 1'b0};
            end else begin
                pins_q.oen_a <= 1'b1;                   // capture keeps pins off.
                pins_q.oen_b <= 1'b1;
            end
        end else if (in_wave) begin
            pins_q.dout_a <= pin_next(pins_q.dout_a, i_match.a, i_cfg.pin_a);
            pins_q.dout_b <= pin_next(pins_q.dout_b, i_match.b, i_cfg.pin_b);
            if (halt_hit) begin
                pins_q.oen_a <= 1'b1;
                pins_q.oen_b <= 1'b1;
            end
        end
    end

    // one pulse per period compare.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            per_hit_d <= 1'b0;
            per_int_q <= 1'b0;
        end else begin
            per_hit_d <= per_hit;
            per_int_q <= per_hit & ~per_hit_d;
        end
    end

    assign o_pins       = pins_q;
    assign o_period_int = per_int_q;

endmodule

`default_nettype wire

/* src/tmr_count.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_count (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire tmr_pkg::tmr_cfg_t     i_cfg,
    input  wire tmr_pkg::tmr_state_e   i_state,
    output logic [`TMR_CNT_W-1:0]      o_count,
    output tmr_pkg::tmr_match_t        o_match
);
    import tmr_pkg::*;

    logic [`TMR_CNT_W-1:0] cnt_q;
    tmr_match_t            match;
    logic                  restart;

    // equality against all six compare values.
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            match.a[i] = (cnt_q == i_cfg.cmp_a[i]);
            match.b[i] = (cnt_q == i_cfg.cmp_b[i]);
        end
    end

    // non-halting period compare reloads zero.
    assign restart = (i_state == st_wave) &&
                     ((match.a[2] && !i_cfg.pin_a.halt) ||
                      (match.b[2] && !i_cfg.pin_b.halt));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!i_cfg.enable) begin
            cnt_q <= '0;
        end else if (i_state != st_idle) begin
            if (restart) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign o_count = cnt_q;
    assign o_match = match;

endmodule

`default_nettype wire

/* src/tmr_mode_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module tmr_mode_fsm (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire tmr_pkg::tmr_cfg_t    i_cfg,
    input  wire tmr_pkg::tmr_events_t i_events,
    input  wire tmr_pkg::tmr_match_t  i_match,
    output tmr_pkg::tmr_state_e       o_state
);
    import tmr_pkg::*;

    tmr_state_e state_q;
    tmr_state_e state_d;
    logic       halt_a_hit;
    logic       halt_b_hit;
    logic       halt_hit;

    // period compare with halt set ends the waveform run.
    assign halt_a_hit = i_match.a[2] & i_cfg.pin_a.halt;
    assign halt_b_hit = i_match.b[2] & i_cfg.pin_b.halt;
    assign halt_hit   = (state_q == st_wave) && (halt_a_hit || halt_b_hit);

    always_comb begin
        state_d = state_q;
        if (!i_cfg.enable) begin
            state_d = st_idle;
        end else if (i_events.stop) begin
            state_d = st_idle;             // stop wins over start.
        end else if (i_events.start) begin
            if (i_cfg.mode == mode_wave) begin
                state_d = st_wave;
            end else begin
                state_d = st_capt;
            end
        end else if (halt_hit) begin
            state_d = st_idle;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_state = state_q;

endmodule

`default_nettype wire

/* src/tmr_event_sync.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmr_defs.svh"

module tmr_event_sync (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire tmr_pkg::tmr_cfg_t       i_cfg,
    input  wire logic                    i_ext_a,
    input  wire logic                    i_ext_b,
    input  wire logic                    i_trig_start,
    input  wire logic                    i_trig_stop,
    input  wire logic [`TMR_INNER_N-1:0] i_inner,
    output tmr_pkg::tmr_events_t         o_events
);
    import tmr_pkg::*;

    tmr_chan_cfg_t [3:0] chan_cfg;
    logic [3:0]          strobe;

    // same bit order as tmr_events_t.
    assign chan_cfg = {i_cfg.ch_start, i_cfg.ch_stop, i_cfg.ch_cap_a, i_cfg.ch_cap_b};

    for (genvar i = 0; i < 4; i++) begin : g_chan
        logic       raw;
        logic [1:0] sync;
        logic       prev;
        logic       hit;

        always_comb begin
            case (chan_cfg[i].src)
                src_ext_a:      raw = i_ext_a;
                src_ext_b:      raw = i_ext_b;
                src_trig_start: raw = i_trig_start;
                src_trig_stop:  raw = i_trig_stop;
                default:        raw = i_inner[chan_cfg[i].src[1:0]]; // inner0..inner3.
            endcase
        end

        // two sync flops, then one more for the edge history.
        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                sync <= 2'b00;
                prev <= 1'b0;
            end else begin
                sync <= {sync[0], raw};
                prev <= sync[1];
            end
        end

        always_comb begin
            case (chan_cfg[i].edge_sel)
                edge_rise: hit = sync[1] & ~prev;
                edge_fall: hit = ~sync[1] & prev;
                edge_both: hit = sync[1] ^ prev;
                default:   hit = 1'b0;
            endcase
        end

        assign strobe[i] = hit;
    end

    assign o_events = tmr_events_t'(strobe);

endmodule

`default_nettype wire

/* src/tmr_pkg.sv */
`default_nettype none

`include "tmr_defs.svh"

package tmr_pkg;

    // edge rule, same coding as the channel config field.
    typedef enum logic [1:0] {
        edge_rise = 2'd0,
        edge_fall = 2'd1,
        edge_both = 2'd2,
        edge_none = 2'd3
    } tmr_edge_e;

    typedef enum logic [`TMR_SEL_W-1:0] {
        src_ext_a      = 3'd0,
        src_ext_b      = 3'd1,
        src_trig_start = 3'd2,
        src_trig_stop  = 3'd3,
        src_inner0     = 3'd4,
        src_inner1     = 3'd5,
        src_inner2     = 3'd6,
        src_inner3     = 3'd7
    } tmr_src_e;

    typedef enum logic {
        mode_capt = 1'b0,
        mode_wave = 1'b1
    } tmr_mode_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_wave = 2'd1,
        st_capt = 2'd2
    } tmr_state_e;

    typedef struct packed {
        tmr_src_e  src;
        tmr_edge_e edge_sel;
    } tmr_chan_cfg_t;

    typedef struct packed {
        logic keep;     // hold level at the period compare.
        logic halt;     // stop instead of restart at the period compare.
        logic idle_lvl;
        logic spare;
    } tmr_pin_cfg_t;

    typedef struct packed {
        logic                        enable;
        tmr_mode_e                   mode;
        tmr_chan_cfg_t               ch_start;
        tmr_chan_cfg_t               ch_stop;
        tmr_chan_cfg_t               ch_cap_a;   // din0.
        tmr_chan_cfg_t               ch_cap_b;   // din1.
        tmr_pin_cfg_t                pin_a;
        tmr_pin_cfg_t                pin_b;
        logic [2:0][`TMR_CNT_W-1:0]  cmp_a;      // a0 clear, a1 set, a2 period.
        logic [2:0][`TMR_CNT_W-1:0]  cmp_b;
        logic [`TMR_BANK_N-1:0]      ovw_a;      // 1 overwrite, 0 discard.
        logic [`TMR_BANK_N-1:0]      ovw_b;
    } tmr_cfg_t;

    typedef struct packed {
        logic start;
        logic stop;
        logic cap_a;
        logic cap_b;
    } tmr_events_t;

    typedef struct packed {
        logic [2:0] a;
        logic [2:0] b;
    } tmr_match_t;

    typedef struct packed {
        logic [`TMR_BANK_N-1:0][`TMR_CNT_W-1:0] values;
        logic [`TMR_BANK_N-1:0]                 status;
    } tmr_bank_t;

    typedef struct packed {
        logic dout_a;
        logic oen_a;    // active low.
        logic dout_b;
        logic oen_b;
    } tmr_pins_t;

endpackage

`default_nettype wire

/* src/tmr_defs.svh */
`ifndef TMR_DEFS_SVH
`define TMR_DEFS_SVH

// counter and compare value width.
`define TMR_CNT_W 32

// width of a channel source code.
// eight sources, pins, trigger pins and inner inputs.
`define TMR_SEL_W 3

// inputs from the neighbouring timers.
`define TMR_INNER_N 4

// entries per capture bank.
`define TMR_BANK_N 3

`endif
